// ==== bus_cfg.svh ====
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// core-side address width
`define BUS_ADDR_W 32

// core-side data width, one 32-bit word
`define BUS_DATA_W 32

// byte strobes per core word
`define BUS_STRB_W (`BUS_DATA_W / 8)

// axi beat is two core words wide
`define BUS_AXI_W (2 * `BUS_DATA_W)

// clint mtime, low word then high word
`define BUS_RTC_ADDR    32'h0200_BFF8
`define BUS_RTC_ADDR_UP 32'h0200_BFFC

// start of main memory behind the axi port
`define BUS_MEM_BASE    32'h8000_0000

`endif

// ==== bus_axi_pkg.sv ====
`include "bus_cfg.svh"

package bus_axi_pkg;

  // arsize / awsize encodings, single beat only
  typedef enum logic [2:0] {
    AXI_SIZE_BYTE = 3'b000,
    AXI_SIZE_HALF = 3'b001,
    AXI_SIZE_WORD = 3'b010
  } axi_size_e;

  // rresp / bresp codes
  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_EXOKAY = 2'b01,
    AXI_RESP_SLVERR = 2'b10,
    AXI_RESP_DECERR = 2'b11
  } axi_resp_e;

  // two core lanes, hi sits at address bit 2 set
  typedef struct packed {
    logic [`BUS_DATA_W-1:0] hi;
    logic [`BUS_DATA_W-1:0] lo;
  } axi_lanes_s;

  // one 64-bit beat, whole word on the bus or split into lanes
  typedef union packed {
    logic [`BUS_AXI_W-1:0] word;
    axi_lanes_s            lane;
  } axi_beat_u;

endpackage

// ==== bus_req_pkg.sv ====
package bus_req_pkg;

  // owner of the transaction in flight
  typedef enum logic [1:0] {
    SRC_IFU_RD = 2'd0,
    SRC_LSU_RD = 2'd1,
    SRC_LSU_WR = 2'd2
  } req_src_e;

  // where the granted request is served
  typedef enum logic {
    TGT_MEM   = 1'b0,
    TGT_TIMER = 1'b1
  } req_target_e;

endpackage

// ==== bus_req_arbiter.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_req_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  // instruction fetch
  input  logic                   ifu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0] ifu_araddr_i,
  // load
  input  logic                   lsu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0] lsu_araddr_i,
  input  logic [`BUS_STRB_W-1:0] lsu_rstrb_i,
  // store
  input  logic                   lsu_wvalid_i,
  input  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0] lsu_wdata_i,
  input  logic [`BUS_STRB_W-1:0] lsu_wstrb_i,
  // end of transaction from stage 3
  input  logic                   done_i,
  // granted request to stage 2
  output logic                   grant_valid_o,
  output bus_req_pkg::req_src_e  grant_src_o,
  output logic [`BUS_ADDR_W-1:0] grant_addr_o,
  output logic [`BUS_STRB_W-1:0] grant_strb_o,
  output logic [`BUS_DATA_W-1:0] grant_wdata_o
);

  logic busy;
  logic accept;

  // only one transaction in the pipeline at a time
  assign accept = !busy && (ifu_arvalid_i || lsu_arvalid_i || lsu_wvalid_i);

  // control: busy from grant until done
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy          <= 1'b0;
      grant_valid_o <= 1'b0;
    end
    else
    begin
      grant_valid_o <= accept;
      if (accept)
      begin
        busy <= 1'b1;
      end
      else if (done_i)
      begin
        busy <= 1'b0;
      end
    end
  end

  // payload, loaded on grant and held for the whole transaction
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      grant_wdata_o <= lsu_wdata_i;
      // lsu store wins, then lsu load, then fetch
      if (lsu_wvalid_i)
      begin
        grant_src_o  <= bus_req_pkg::SRC_LSU_WR;
        grant_addr_o <= lsu_awaddr_i;
        grant_strb_o <= lsu_wstrb_i;
      end
      else if (lsu_arvalid_i)
      begin
        grant_src_o  <= bus_req_pkg::SRC_LSU_RD;
        grant_addr_o <= lsu_araddr_i;
        grant_strb_o <= lsu_rstrb_i;
      end
      else
      begin
        grant_src_o  <= bus_req_pkg::SRC_IFU_RD;
        grant_addr_o <= ifu_araddr_i;
        // fetch is always a full word
        grant_strb_o <= {`BUS_STRB_W{1'b1}};
      end
    end
  end

endmodule

// ==== bus_target_decode.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_target_decode (
  input  logic                     clk,
  input  logic                     rst,
  // from stage 1
  input  logic                     grant_valid_i,
  input  bus_req_pkg::req_src_e    grant_src_i,
  input  logic [`BUS_ADDR_W-1:0]   grant_addr_i,
  input  logic [`BUS_STRB_W-1:0]   grant_strb_i,
  input  logic [`BUS_DATA_W-1:0]   grant_wdata_i,
  // to stage 3 and the timer
  output logic                     dec_valid_o,
  output bus_req_pkg::req_target_e dec_target_o,
  output bus_req_pkg::req_src_e    dec_src_o,
  output logic [`BUS_ADDR_W-1:0]   dec_addr_o,
  output logic [`BUS_STRB_W-1:0]   dec_strb_o,
  output logic [`BUS_DATA_W-1:0]   dec_wdata_o
);

  logic is_rtc;
  logic is_timer;

  // either mtime word
  assign is_rtc = (grant_addr_i == `BUS_RTC_ADDR) || (grant_addr_i == `BUS_RTC_ADDR_UP);
  // timer is read-only here, fetches never hit it
  assign is_timer = is_rtc && (grant_src_i == bus_req_pkg::SRC_LSU_RD);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dec_valid_o <= 1'b0;
    end
    else
    begin
      dec_valid_o <= grant_valid_i;
    end
  end

  // fields stay put until the next grant
  always_ff @(posedge clk)
  begin
    if (grant_valid_i)
    begin
      dec_target_o <= is_timer ? bus_req_pkg::TGT_TIMER : bus_req_pkg::TGT_MEM;
      dec_src_o    <= grant_src_i;
      dec_addr_o   <= grant_addr_i;
      dec_strb_o   <= grant_strb_i;
      dec_wdata_o  <= grant_wdata_i;
    end
  end

endmodule

// ==== bus_clint_timer.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_clint_timer (
  input  logic                   clk,
  input  logic                   rst,
  // read strobe and word select
  input  logic                   rd_valid_i,
  input  logic                   rd_hi_i,
  // read result, one cycle later
  output logic [`BUS_DATA_W-1:0] rdata_o,
  output logic                   rvalid_o
);

  // mtime, counts core clocks
  logic [2*`BUS_DATA_W-1:0] mtime;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime <= '0;
    end
    else
    begin
      mtime <= mtime + 1'b1;
    end
  end

  // response pulse
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rvalid_o <= 1'b0;
    end
    else
    begin
      rvalid_o <= rd_valid_i;
    end
  end

  // word captured with the strobe
  always_ff @(posedge clk)
  begin
    if (rd_valid_i)
    begin
      rdata_o <= rd_hi_i ? mtime[2*`BUS_DATA_W-1:`BUS_DATA_W] : mtime[`BUS_DATA_W-1:0];
    end
  end

endmodule

// ==== bus_axi_issue.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_axi_issue (
  input  logic                     clk,
  input  logic                     rst,
  // decoded request, fields stable while busy
  input  logic                     dec_valid_i,
  input  bus_req_pkg::req_target_e dec_target_i,
  input  bus_req_pkg::req_src_e    dec_src_i,
  input  logic [`BUS_ADDR_W-1:0]   dec_addr_i,
  input  logic [`BUS_STRB_W-1:0]   dec_strb_i,
  input  logic [`BUS_DATA_W-1:0]   dec_wdata_i,
  // timer read result
  input  logic [`BUS_DATA_W-1:0]   timer_rdata_i,
  input  logic                     timer_rvalid_i,
  // axi read address
  output logic                     io_master_arvalid_o,
  input  logic                     io_master_arready_i,
  output logic [`BUS_ADDR_W-1:0]   io_master_araddr_o,
  output bus_axi_pkg::axi_size_e   io_master_arsize_o,
  // axi read data
  input  logic                     io_master_rvalid_i,
  output logic                     io_master_rready_o,
  input  logic [`BUS_AXI_W-1:0]    io_master_rdata_i,
  input  bus_axi_pkg::axi_resp_e   io_master_rresp_i,
  // axi write address
  output logic                     io_master_awvalid_o,
  input  logic                     io_master_awready_i,
  output logic [`BUS_ADDR_W-1:0]   io_master_awaddr_o,
  output bus_axi_pkg::axi_size_e   io_master_awsize_o,
  // axi write data
  output logic                     io_master_wvalid_o,
  input  logic                     io_master_wready_i,
  output logic [`BUS_AXI_W-1:0]    io_master_wdata_o,
  output logic [2*`BUS_STRB_W-1:0] io_master_wstrb_o,
  output logic                     io_master_wlast_o,
  // axi write response
  input  logic                     io_master_bvalid_i,
  output logic                     io_master_bready_o,
  input  bus_axi_pkg::axi_resp_e   io_master_bresp_i,
  // core-side responses
  output logic [`BUS_DATA_W-1:0]   ifu_rdata_o,
  output logic                     ifu_rvalid_o,
  output logic [`BUS_DATA_W-1:0]   lsu_rdata_o,
  output logic                     lsu_rvalid_o,
  output logic                     lsu_wready_o,
  // timer read request
  output logic                     timer_rd_valid_o,
  output logic                     timer_rd_hi_o,
  // transaction finished, frees stage 1
  output logic                     done_o
);

  bus_axi_pkg::axi_beat_u rbeat;
  bus_axi_pkg::axi_beat_u wbeat;
  bus_axi_pkg::axi_size_e size;
  logic                   to_mem;
  logic                   start_rd;
  logic                   start_wr;
  logic                   rd_wait;
  logic                   wr_wait;
  logic                   rd_done;
  logic                   wr_done;
  logic                   rd_resp;
  logic [`BUS_DATA_W-1:0] rd_data;

  // strobe pattern to axi size, odd patterns fall back to byte
  function automatic bus_axi_pkg::axi_size_e strb_to_size(input logic [`BUS_STRB_W-1:0] strb);
    case (strb)
      4'h3:    return bus_axi_pkg::AXI_SIZE_HALF;
      4'hf:    return bus_axi_pkg::AXI_SIZE_WORD;
      default: return bus_axi_pkg::AXI_SIZE_BYTE;
    endcase
  endfunction

  assign to_mem   = dec_valid_i && (dec_target_i == bus_req_pkg::TGT_MEM);
  assign start_wr = to_mem && (dec_src_i == bus_req_pkg::SRC_LSU_WR);
  assign start_rd = to_mem && (dec_src_i != bus_req_pkg::SRC_LSU_WR);

  // timer path, word picked by address bit 2
  assign timer_rd_valid_o = dec_valid_i && (dec_target_i == bus_req_pkg::TGT_TIMER);
  assign timer_rd_hi_o    = dec_addr_i[2];

  // address and size come straight from the held decode fields
  assign size               = strb_to_size(dec_strb_i);
  assign io_master_araddr_o = dec_addr_i;
  assign io_master_arsize_o = size;
  assign io_master_awaddr_o = dec_addr_i;
  assign io_master_awsize_o = size;

  // store word goes out on both lanes
  assign wbeat.lane.hi     = dec_wdata_i;
  assign wbeat.lane.lo     = dec_wdata_i;
  assign io_master_wdata_o = wbeat.word;
  // strobes follow the lane of address bit 2
  assign io_master_wstrb_o = dec_addr_i[2] ? {dec_strb_i, {`BUS_STRB_W{1'b0}}}
                                           : {{`BUS_STRB_W{1'b0}}, dec_strb_i};
  // every beat is the last one
  assign io_master_wlast_o = io_master_wvalid_o;

  // responses are always taken
  assign io_master_rready_o = 1'b1;
  assign io_master_bready_o = 1'b1;

  // read channel state
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      io_master_arvalid_o <= 1'b0;
      rd_wait             <= 1'b0;
    end
    else
    begin
      if (start_rd)
      begin
        io_master_arvalid_o <= 1'b1;
      end
      else if (io_master_arready_i)
      begin
        io_master_arvalid_o <= 1'b0;
      end
      if (start_rd)
      begin
        rd_wait <= 1'b1;
      end
      else if (rd_done)
      begin
        rd_wait <= 1'b0;
      end
    end
  end

  // write channel state, aw and w drop on their own handshakes
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      io_master_awvalid_o <= 1'b0;
      io_master_wvalid_o  <= 1'b0;
      wr_wait             <= 1'b0;
    end
    else
    begin
      if (start_wr)
      begin
        io_master_awvalid_o <= 1'b1;
        io_master_wvalid_o  <= 1'b1;
        wr_wait             <= 1'b1;
      end
      else
      begin
        if (io_master_awready_i)
        begin
          io_master_awvalid_o <= 1'b0;
        end
        if (io_master_wready_i)
        begin
          io_master_wvalid_o <= 1'b0;
        end
        if (wr_done)
        begin
          wr_wait <= 1'b0;
        end
      end
    end
  end

  assign rd_done = rd_wait && io_master_rvalid_i;
  assign wr_done = wr_wait && io_master_bvalid_i;

  // read lane picked by address bit 2
  assign rbeat.word = io_master_rdata_i;
  assign rd_resp    = rd_done || timer_rvalid_i;
  assign rd_data    = timer_rvalid_i ? timer_rdata_i
                    : (dec_addr_i[2] ? rbeat.lane.hi : rbeat.lane.lo);

  // route the pulse to the recorded owner
  assign ifu_rdata_o  = rd_data;
  assign ifu_rvalid_o = rd_resp && (dec_src_i == bus_req_pkg::SRC_IFU_RD);
  assign lsu_rdata_o  = rd_data;
  assign lsu_rvalid_o = rd_resp && (dec_src_i == bus_req_pkg::SRC_LSU_RD);
  assign lsu_wready_o = wr_done;
  assign done_o       = rd_resp || wr_done;

endmodule

// ==== bus_top.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_top (
  input  logic                     clk,
  input  logic                     rst,
  // fetch unit
  input  logic                     ifu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0]   ifu_araddr_i,
  output logic [`BUS_DATA_W-1:0]   ifu_rdata_o,
  output logic                     ifu_rvalid_o,
  // load/store unit, load side
  input  logic                     lsu_arvalid_i,
  input  logic [`BUS_ADDR_W-1:0]   lsu_araddr_i,
  input  logic [`BUS_STRB_W-1:0]   lsu_rstrb_i,
  output logic [`BUS_DATA_W-1:0]   lsu_rdata_o,
  output logic                     lsu_rvalid_o,
  // load/store unit, store side
  input  logic                     lsu_wvalid_i,
  input  logic [`BUS_ADDR_W-1:0]   lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0]   lsu_wdata_i,
  input  logic [`BUS_STRB_W-1:0]   lsu_wstrb_i,
  output logic                     lsu_wready_o,
  // axi4 master
  output logic                     io_master_arvalid_o,
  input  logic                     io_master_arready_i,
  output logic [`BUS_ADDR_W-1:0]   io_master_araddr_o,
  output bus_axi_pkg::axi_size_e   io_master_arsize_o,
  input  logic                     io_master_rvalid_i,
  output logic                     io_master_rready_o,
  input  logic [`BUS_AXI_W-1:0]    io_master_rdata_i,
  input  bus_axi_pkg::axi_resp_e   io_master_rresp_i,
  output logic                     io_master_awvalid_o,
  input  logic                     io_master_awready_i,
  output logic [`BUS_ADDR_W-1:0]   io_master_awaddr_o,
  output bus_axi_pkg::axi_size_e   io_master_awsize_o,
  output logic                     io_master_wvalid_o,
  input  logic                     io_master_wready_i,
  output logic [`BUS_AXI_W-1:0]    io_master_wdata_o,
  output logic [2*`BUS_STRB_W-1:0] io_master_wstrb_o,
  output logic                     io_master_wlast_o,
  input  logic                     io_master_bvalid_i,
  output logic                     io_master_bready_o,
  input  bus_axi_pkg::axi_resp_e   io_master_bresp_i
);

  // stage 1 to stage 2
  logic                     grant_valid;
  bus_req_pkg::req_src_e    grant_src;
  logic [`BUS_ADDR_W-1:0]   grant_addr;
  logic [`BUS_STRB_W-1:0]   grant_strb;
  logic [`BUS_DATA_W-1:0]   grant_wdata;
  // stage 2 to stage 3
  logic                     dec_valid;
  bus_req_pkg::req_target_e dec_target;
  bus_req_pkg::req_src_e    dec_src;
  logic [`BUS_ADDR_W-1:0]   dec_addr;
  logic [`BUS_STRB_W-1:0]   dec_strb;
  logic [`BUS_DATA_W-1:0]   dec_wdata;
  // timer side path and completion
  logic                     timer_rd_valid;
  logic                     timer_rd_hi;
  logic [`BUS_DATA_W-1:0]   timer_rdata;
  logic                     timer_rvalid;
  logic                     done;

  bus_req_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .done_i        (done),
    .grant_valid_o (grant_valid),
    .grant_src_o   (grant_src),
    .grant_addr_o  (grant_addr),
    .grant_strb_o  (grant_strb),
    .grant_wdata_o (grant_wdata)
  );

  bus_target_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .grant_valid_i (grant_valid),
    .grant_src_i   (grant_src),
    .grant_addr_i  (grant_addr),
    .grant_strb_i  (grant_strb),
    .grant_wdata_i (grant_wdata),
    .dec_valid_o   (dec_valid),
    .dec_target_o  (dec_target),
    .dec_src_o     (dec_src),
    .dec_addr_o    (dec_addr),
    .dec_strb_o    (dec_strb),
    .dec_wdata_o   (dec_wdata)
  );

  bus_clint_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .rd_valid_i (timer_rd_valid),
    .rd_hi_i    (timer_rd_hi),
    .rdata_o    (timer_rdata),
    .rvalid_o   (timer_rvalid)
  );

  bus_axi_issue u_issue (
    .clk                 (clk),
    .rst                 (rst),
    .dec_valid_i         (dec_valid),
    .dec_target_i        (dec_target),
    .dec_src_i           (dec_src),
    .dec_addr_i          (dec_addr),
    .dec_strb_i          (dec_strb),
    .dec_wdata_i         (dec_wdata),
    .timer_rdata_i       (timer_rdata),
    .timer_rvalid_i      (timer_rvalid),
    .io_master_arvalid_o (io_master_arvalid_o),
    .io_master_arready_i (io_master_arready_i),
    .io_master_araddr_o  (io_master_araddr_o),
    .io_master_arsize_o  (io_master_arsize_o),
    .io_master_rvalid_i  (io_master_rvalid_i),
    .io_master_rready_o  (io_master_rready_o),
    .io_master_rdata_i   (io_master_rdata_i),
    .io_master_rresp_i   (io_master_rresp_i),
    .io_master_awvalid_o (io_master_awvalid_o),
    .io_master_awready_i (io_master_awready_i),
    .io_master_awaddr_o  (io_master_awaddr_o),
    .io_master_awsize_o  (io_master_awsize_o),
    .io_master_wvalid_o  (io_master_wvalid_o),
    .io_master_wready_i  (io_master_wready_i),
    .io_master_wdata_o   (io_master_wdata_o),
    .io_master_wstrb_o   (io_master_wstrb_o),
    .io_master_wlast_o   (io_master_wlast_o),
    .io_master_bvalid_i  (io_master_bvalid_i),
    .io_master_bready_o  (io_master_bready_o),
    .io_master_bresp_i   (io_master_bresp_i),
    .ifu_rdata_o         (ifu_rdata_o),
    .ifu_rvalid_o        (ifu_rvalid_o),
    .lsu_rdata_o         (lsu_rdata_o),
    .lsu_rvalid_o        (lsu_rvalid_o),
    .lsu_wready_o        (lsu_wready_o),
    .timer_rd_valid_o    (timer_rd_valid),
    .timer_rd_hi_o       (timer_rd_hi),
    .done_o              (done)
  );

endmodule

// ==== bus_sva.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_sva (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   arvalid_i,
  input  logic                   arready_i,
  input  logic [`BUS_ADDR_W-1:0] araddr_i,
  input  logic                   awvalid_i,
  input  logic                   rvalid_i,
  input  bus_axi_pkg::axi_resp_e rresp_i,
  input  logic                   bvalid_i,
  input  bus_axi_pkg::axi_resp_e bresp_i,
  input  logic                   ifu_rvalid_i,
  input  logic                   lsu_rvalid_i
);

  // one flag per property, set on the first failure
  logic excl_bad = 1'b0;
  logic hold_bad = 1'b0;
  logic resp_bad = 1'b0;
  logic rresp_bad = 1'b0;
  logic bresp_bad = 1'b0;
  logic fail_seen;

  assign fail_seen = excl_bad || hold_bad || resp_bad || rresp_bad || bresp_bad;

  // single outstanding access, never a read and a write at once
  excl_chk: assert property (@(posedge clk) disable iff (rst) !(arvalid_i && awvalid_i))
    else begin excl_bad = 1'b1; $error("arvalid and awvalid high together"); end

  // ar held until the slave takes it
  hold_chk: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin hold_bad = 1'b1; $error("arvalid or araddr changed before arready"); end

  // one requester answered per cycle
  resp_chk: assert property (@(posedge clk) disable iff (rst) !(ifu_rvalid_i && lsu_rvalid_i))
    else begin resp_bad = 1'b1; $error("ifu and lsu response pulses coincide"); end

  // no error recovery, so only OKAY is legal
  rresp_chk: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> rresp_i == bus_axi_pkg::AXI_RESP_OKAY)
    else begin rresp_bad = 1'b1; $error("rresp is not OKAY"); end

  bresp_chk: assert property (@(posedge clk) disable iff (rst)
    bvalid_i |-> bresp_i == bus_axi_pkg::AXI_RESP_OKAY)
    else begin bresp_bad = 1'b1; $error("bresp is not OKAY"); end

endmodule

bind bus_axi_issue bus_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .arvalid_i    (io_master_arvalid_o),
  .arready_i    (io_master_arready_i),
  .araddr_i     (io_master_araddr_o),
  .awvalid_i    (io_master_awvalid_o),
  .rvalid_i     (io_master_rvalid_i),
  .rresp_i      (io_master_rresp_i),
  .bvalid_i     (io_master_bvalid_i),
  .bresp_i      (io_master_bresp_i),
  .ifu_rvalid_i (ifu_rvalid_o),
  .lsu_rvalid_i (lsu_rvalid_o)
);

// ==== bus_tb.sv ====
`timescale 1ns/10ps
`include "bus_cfg.svh"

module bus_tb;

  localparam int RESP_TIMEOUT = 200;
  localparam logic [31:0] MB = `BUS_MEM_BASE;

  typedef struct {
    bus_req_pkg::req_src_e  src;
    logic [31:0]            addr;
    logic [3:0]             strb;
    logic [31:0]            data;
    logic [31:0]            exp;
    bus_axi_pkg::axi_size_e size;
  } step_t;

  logic clk = 1'b0;
  logic rst;
  // core side
  logic        ifu_arvalid, lsu_arvalid, lsu_wvalid;
  logic [31:0] ifu_araddr, lsu_araddr, lsu_awaddr, lsu_wdata;
  logic [3:0]  lsu_rstrb, lsu_wstrb;
  logic [31:0] ifu_rdata, lsu_rdata;
  logic        ifu_rvalid, lsu_rvalid, lsu_wready;
  // axi side with the slave inputs idle at start
  logic        arvalid, rready, awvalid, wvalid, wlast, bready;
  logic        arready = 1'b0;
  logic        awready = 1'b0;
  logic        wready = 1'b0;
  logic        rvalid = 1'b0;
  logic        bvalid = 1'b0;
  logic [63:0] rdata = '0;
  logic [31:0] araddr, awaddr;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  bus_axi_pkg::axi_size_e arsize, awsize;
  bus_axi_pkg::axi_resp_e rresp = bus_axi_pkg::AXI_RESP_OKAY;
  bus_axi_pkg::axi_resp_e bresp = bus_axi_pkg::AXI_RESP_OKAY;

  // memory model state
  logic [63:0] mem [0:15];
  logic [31:0] ar_addr_q, aw_addr_q;
  logic [63:0] w_data_q;
  logic [7:0]  w_strb_q;
  logic        w_last_q;
  logic        ar_got, aw_got, w_got;
  int unsigned rd_cnt, wr_cnt, ar_seen;
  bus_axi_pkg::axi_size_e last_arsize, last_awsize;
  step_t steps[$];

  bus_top DUT (
    .clk(clk), .rst(rst),
    .ifu_arvalid_i(ifu_arvalid), .ifu_araddr_i(ifu_araddr),
    .ifu_rdata_o(ifu_rdata), .ifu_rvalid_o(ifu_rvalid),
    .lsu_arvalid_i(lsu_arvalid), .lsu_araddr_i(lsu_araddr), .lsu_rstrb_i(lsu_rstrb),
    .lsu_rdata_o(lsu_rdata), .lsu_rvalid_o(lsu_rvalid),
    .lsu_wvalid_i(lsu_wvalid), .lsu_awaddr_i(lsu_awaddr), .lsu_wdata_i(lsu_wdata),
    .lsu_wstrb_i(lsu_wstrb), .lsu_wready_o(lsu_wready),
    .io_master_arvalid_o(arvalid), .io_master_arready_i(arready),
    .io_master_araddr_o(araddr), .io_master_arsize_o(arsize),
    .io_master_rvalid_i(rvalid), .io_master_rready_o(rready),
    .io_master_rdata_i(rdata), .io_master_rresp_i(rresp),
    .io_master_awvalid_o(awvalid), .io_master_awready_i(awready),
    .io_master_awaddr_o(awaddr), .io_master_awsize_o(awsize),
    .io_master_wvalid_o(wvalid), .io_master_wready_i(wready),
    .io_master_wdata_o(wdata), .io_master_wstrb_o(wstrb), .io_master_wlast_o(wlast),
    .io_master_bvalid_i(bvalid), .io_master_bready_o(bready), .io_master_bresp_i(bresp)
  );

  always #20 clk = ~clk;

  // preload pattern tied to the full byte address of each lane
  function automatic logic [31:0] lane_fill(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h3C5A_A5C3;
  endfunction

  // axi slave with random ready and response delays
  always @(posedge clk)
  begin
    if (rst)
    begin
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      rvalid  <= 1'b0;
      bvalid  <= 1'b0;
      ar_got  <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      ar_seen <= 0;
      for (int k = 0; k < 16; k++)
      begin
        mem[k] <= {lane_fill(MB + 32'(8 * k + 4)), lane_fill(MB + 32'(8 * k))};
      end
    end
    else
    begin
      arready <= ($urandom % 3) == 0;
      awready <= ($urandom % 3) == 0;
      wready  <= ($urandom % 3) == 0;
      if (arvalid)
      begin
        ar_seen <= ar_seen + 1;
      end
      // read address then a delayed single beat
      if (arvalid && arready)
      begin
        ar_got      <= 1'b1;
        ar_addr_q   <= araddr;
        last_arsize <= arsize;
        rd_cnt      <= $urandom % 4;
      end
      if (rvalid && rready)
      begin
        rvalid <= 1'b0;
      end
      else if (ar_got)
      begin
        if (rd_cnt == 0)
        begin
          rvalid <= 1'b1;
          rdata  <= mem[ar_addr_q[6:3]];
          ar_got <= 1'b0;
        end
        else
        begin
          rd_cnt <= rd_cnt - 1;
        end
      end
      // aw and w may land in either order
      if (awvalid && awready)
      begin
        aw_got      <= 1'b1;
        aw_addr_q   <= awaddr;
        last_awsize <= awsize;
        wr_cnt      <= $urandom % 4;
      end
      if (wvalid && wready)
      begin
        w_got    <= 1'b1;
        w_data_q <= wdata;
        w_strb_q <= wstrb;
        w_last_q <= wlast;
      end
      if (bvalid && bready)
      begin
        bvalid <= 1'b0;
      end
      else if (aw_got && w_got)
      begin
        if (wr_cnt == 0)
        begin
          // byte merge under wstrb
          for (int b = 0; b < 8; b++)
          begin
            if (w_strb_q[b])
            begin
              mem[aw_addr_q[6:3]][8*b +: 8] <= w_data_q[8*b +: 8];
            end
          end
          bvalid <= 1'b1;
          aw_got <= 1'b0;
          w_got  <= 1'b0;
        end
        else
        begin
          wr_cnt <= wr_cnt - 1;
        end
      end
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // stop at the first assertion failure on the axi side
  always @(posedge clk)
  begin
    if (DUT.u_issue.u_sva.fail_seen)
    begin
      abort_run("an assertion on the AXI side failed");
    end
  end

  task automatic raise_req(input bus_req_pkg::req_src_e src, input logic [31:0] addr,
                           input logic [3:0] strb, input logic [31:0] data);
    case (src)
      bus_req_pkg::SRC_IFU_RD:
      begin
        ifu_arvalid <= 1'b1;
        ifu_araddr  <= addr;
      end
      bus_req_pkg::SRC_LSU_RD:
      begin
        lsu_arvalid <= 1'b1;
        lsu_araddr  <= addr;
        lsu_rstrb   <= strb;
      end
      default:
      begin
        lsu_wvalid <= 1'b1;
        lsu_awaddr <= addr;
        lsu_wdata  <= data;
        lsu_wstrb  <= strb;
      end
    endcase
  endtask

  // waits for the owner's pulse and drops its level on that edge
  task automatic wait_resp(input bus_req_pkg::req_src_e src, output logic [31:0] data);
    int   cycles;
    logic hit;
    logic stray;
    cycles = 0;
    hit = 1'b0;
    data = '0;
    while (!hit)
    begin
      @(posedge clk);
      cycles++;
      if (cycles > RESP_TIMEOUT)
      begin
        abort_run("no response pulse arrived within the timeout");
      end
      case (src)
        bus_req_pkg::SRC_IFU_RD:
        begin
          hit   = ifu_rvalid;
          stray = lsu_rvalid || lsu_wready;
          data  = ifu_rdata;
        end
        bus_req_pkg::SRC_LSU_RD:
        begin
          hit   = lsu_rvalid;
          stray = ifu_rvalid || lsu_wready;
          data  = lsu_rdata;
        end
        default:
        begin
          hit   = lsu_wready;
          stray = ifu_rvalid || lsu_rvalid;
        end
      endcase
      if (stray)
      begin
        abort_run("a response pulse went to the wrong requester");
      end
    end
    case (src)
      bus_req_pkg::SRC_IFU_RD: ifu_arvalid <= 1'b0;
      bus_req_pkg::SRC_LSU_RD: lsu_arvalid <= 1'b0;
      default:                 lsu_wvalid  <= 1'b0;
    endcase
  endtask

  task automatic run_request(input bus_req_pkg::req_src_e src, input logic [31:0] addr,
                             input logic [3:0] strb, input logic [31:0] data,
                             output logic [31:0] got);
    @(posedge clk);
    raise_req(src, addr, strb, data);
    wait_resp(src, got);
  endtask

  function automatic void add_step(input bus_req_pkg::req_src_e src, input logic [31:0] addr,
                                   input logic [3:0] strb, input logic [31:0] data,
                                   input logic [31:0] exp, input bus_axi_pkg::axi_size_e size);
    step_t st;
    st = '{src, addr, strb, data, exp, size};
    steps.push_back(st);
  endfunction

  initial
  begin
    logic [31:0] got;
    logic [31:0] t_lo0;
    logic [31:0] t_lo1;
    logic [31:0] t_hi;
    int unsigned ar_before;
    void'($urandom(20416));
    rst <= 1'b1;
    ifu_arvalid <= 1'b0;
    lsu_arvalid <= 1'b0;
    lsu_wvalid  <= 1'b0;
    ifu_araddr  <= '0;
    lsu_araddr  <= '0;
    lsu_awaddr  <= '0;
    lsu_wdata   <= '0;
    lsu_rstrb   <= '0;
    lsu_wstrb   <= '0;
    // fetches from both lanes
    add_step(bus_req_pkg::SRC_IFU_RD, MB + 32'h00, 4'hF, '0, lane_fill(MB + 32'h00),
             bus_axi_pkg::AXI_SIZE_WORD);
    add_step(bus_req_pkg::SRC_IFU_RD, MB + 32'h0C, 4'hF, '0, lane_fill(MB + 32'h0C),
             bus_axi_pkg::AXI_SIZE_WORD);
    // loads where the strobe sets the size and the whole lane comes back
    add_step(bus_req_pkg::SRC_LSU_RD, MB + 32'h10, 4'h1, '0, lane_fill(MB + 32'h10),
             bus_axi_pkg::AXI_SIZE_BYTE);
    add_step(bus_req_pkg::SRC_LSU_RD, MB + 32'h14, 4'h3, '0, lane_fill(MB + 32'h14),
             bus_axi_pkg::AXI_SIZE_HALF);
    add_step(bus_req_pkg::SRC_LSU_RD, MB + 32'h18, 4'hF, '0, lane_fill(MB + 32'h18),
             bus_axi_pkg::AXI_SIZE_WORD);
    // stores followed by reads of the merged word
    // for a store exp holds the 8-bit axi wstrb
    add_step(bus_req_pkg::SRC_LSU_WR, MB + 32'h24, 4'hF, 32'hCAFE_F00D, 32'h0000_00F0,
             bus_axi_pkg::AXI_SIZE_WORD);
    add_step(bus_req_pkg::SRC_LSU_RD, MB + 32'h24, 4'hF, '0, 32'hCAFE_F00D,
             bus_axi_pkg::AXI_SIZE_WORD);
    add_step(bus_req_pkg::SRC_LSU_RD, MB + 32'h20, 4'hF, '0, lane_fill(MB + 32'h20),
             bus_axi_pkg::AXI_SIZE_WORD);
    add_step(bus_req_pkg::SRC_LSU_WR, MB + 32'h28, 4'h3, 32'h5555_1234, 32'h0000_0003,
             bus_axi_pkg::AXI_SIZE_HALF);
    add_step(bus_req_pkg::SRC_LSU_RD, MB + 32'h28, 4'hF, '0,
             (lane_fill(MB + 32'h28) & 32'hFFFF_0000) | 32'h0000_1234,
             bus_axi_pkg::AXI_SIZE_WORD);
    add_step(bus_req_pkg::SRC_LSU_WR, MB + 32'h3C, 4'h1, 32'h6666_66AB, 32'h0000_0010,
             bus_axi_pkg::AXI_SIZE_BYTE);
    add_step(bus_req_pkg::SRC_IFU_RD, MB + 32'h3C, 4'hF, '0,
             (lane_fill(MB + 32'h3C) & 32'hFFFF_FF00) | 32'h0000_00AB,
             bus_axi_pkg::AXI_SIZE_WORD);
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    foreach (steps[n])
    begin
      run_request(steps[n].src, steps[n].addr, steps[n].strb, steps[n].data, got);
      if (steps[n].src == bus_req_pkg::SRC_LSU_WR)
      begin
        // data on both lanes and strobes on the addressed lane
        compare("wdata", w_data_q, {steps[n].data, steps[n].data});
        compare("wstrb", 64'(w_strb_q), 64'(steps[n].exp));
        compare("wlast", 64'(w_last_q), 64'd1);
        compare("awsize", 64'(last_awsize), 64'(steps[n].size));
        compare("bready", 64'(bready), 64'd1);
      end
      else
      begin
        compare("rdata", 64'(got), 64'(steps[n].exp));
        compare("arsize", 64'(last_arsize), 64'(steps[n].size));
        compare("rready", 64'(rready), 64'd1);
      end
    end

    // fetch and load raised on one edge with the load served first
    @(posedge clk);
    raise_req(bus_req_pkg::SRC_IFU_RD, MB + 32'h08, 4'hF, '0);
    raise_req(bus_req_pkg::SRC_LSU_RD, MB + 32'h34, 4'hF, '0);
    wait_resp(bus_req_pkg::SRC_LSU_RD, got);
    compare("lsu_rdata", 64'(got), 64'(lane_fill(MB + 32'h34)));
    wait_resp(bus_req_pkg::SRC_IFU_RD, got);
    compare("ifu_rdata", 64'(got), 64'(lane_fill(MB + 32'h08)));

    // timer reads stay off the bus
    ar_before = ar_seen;
    run_request(bus_req_pkg::SRC_LSU_RD, `BUS_RTC_ADDR, 4'hF, '0, t_lo0);
    run_request(bus_req_pkg::SRC_LSU_RD, `BUS_RTC_ADDR, 4'hF, '0, t_lo1);
    run_request(bus_req_pkg::SRC_LSU_RD, `BUS_RTC_ADDR_UP, 4'hF, '0, t_hi);
    compare("arvalid cycles", 64'(ar_seen), 64'(ar_before));
    compare("mtime_lo increase", 64'(t_lo1 > t_lo0), 64'd1);
    compare("mtime_hi", 64'(t_hi), 64'd0);

    @(posedge clk);
    if (DUT.u_issue.u_sva.fail_seen)
    begin
      abort_run("an assertion on the AXI side failed");
    end
    else
    begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== bus_subsys.f ====
+incdir+.
bus_axi_pkg.sv
bus_req_pkg.sv
bus_req_arbiter.sv
bus_target_decode.sv
bus_clint_timer.sv
bus_axi_issue.sv
bus_top.sv
bus_sva.sv
bus_tb.sv

// ==== Makefile ====
# Verilator build and run of the bus front end testbench

VERILATOR ?= verilator
TOP       ?= bus_tb
FILELIST  ?= bus_subsys.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
